// ==== include/sd_dat_config.svh ====
`ifndef SD_DAT_CONFIG_SVH
`define SD_DAT_CONFIG_SVH

// ========================================
// SD DAT receive configuration
// ========================================

// Number of DAT lines on the card bus
`define SD_LANES 4

// Data nibbles in one 512-bit block
`define SD_BLOCK_NIBBLES 128

// Nibbles packed into one output word
`define SD_WORD_NIBBLES 4

// CRC length sent after the data on each lane
`define SD_CRC_BITS 16

// CRC16-CCITT, x^16 + x^12 + x^5 + 1
`define SD_CRC16_POLY 16'h1021

`endif

// ==== rtl/sd_bus_pkg.sv ====
`default_nettype none

`include "sd_dat_config.svh"

package sd_bus_pkg;

    // One sample of all DAT lines, bit i is DAT[i]
    typedef logic [`SD_LANES-1:0] nibble_t;

    // Output word, first nibble received sits in the top bits
    typedef logic [`SD_WORD_NIBBLES*`SD_LANES-1:0] data_word_t;

    // Receive sequence
    typedef enum logic [2:0] {
        rx_idle    = 3'd0,
        // Waiting for the start bit on DAT0
        rx_armed   = 3'd1,
        rx_data    = 3'd2,
        rx_crc     = 3'd3,
        rx_end_bit = 3'd4
    } rx_phase_t;

endpackage

`default_nettype wire

// ==== rtl/sd_crc_pkg.sv ====
`default_nettype none

`include "sd_dat_config.svh"

package sd_crc_pkg;

    // Per-lane CRC remainder
    typedef logic [`SD_CRC_BITS-1:0] crc16_t;

    // One flag per DAT line, bit i belongs to DAT[i]
    typedef logic [`SD_LANES-1:0] lane_err_t;

endpackage

`default_nettype wire

// ==== rtl/sd_lane_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// Framed nibble stream shared by the lane checkers and the collector
interface sd_lane_if;

    sd_bus_pkg::rx_phase_t phase;
    sd_bus_pkg::nibble_t   nibble;
    // Single cycle, just before the first data nibble
    logic                  block_start;
    // Fourth nibble of a word in the data phase
    logic                  word_last;

    modport source (
        output phase,
        output nibble,
        output block_start,
        output word_last
    );

    modport sink (
        input phase,
        input nibble,
        input block_start,
        input word_last
    );

endinterface

`default_nettype wire

// ==== rtl/sd_dat_framer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sd_dat_config.svh"

module sd_dat_framer (
    input  logic                clk_fast,
    input  logic                rst_n,
    input  logic                rx_start,
    input  sd_bus_pkg::nibble_t dat_in,
    output logic                dat0_idle,
    sd_lane_if.source           lane
);

    localparam int cnt_w  = $clog2(`SD_BLOCK_NIBBLES);
    localparam int word_w = $clog2(`SD_WORD_NIBBLES);

    localparam logic [cnt_w-1:0]  data_last = cnt_w'(`SD_BLOCK_NIBBLES - 1);
    localparam logic [cnt_w-1:0]  crc_last  = cnt_w'(`SD_CRC_BITS - 1);
    localparam logic [word_w-1:0] word_end  = word_w'(`SD_WORD_NIBBLES - 1);

    sd_bus_pkg::nibble_t   dat_q;
    sd_bus_pkg::rx_phase_t phase_q;
    logic [cnt_w-1:0]      nib_cnt;
    logic                  start_seen;

    // ========================================
    // Input sampling
    // ========================================
    always_ff @(posedge clk_fast or negedge rst_n) begin
        if (!rst_n) begin
            dat_q <= '0;
        end else begin
            dat_q <= dat_in;
        end
    end

    // Start bit is DAT0 low, other lanes don't matter
    assign start_seen = (phase_q == sd_bus_pkg::rx_armed) && !dat_q[0];

    // ========================================
    // Phase sequencing
    // ========================================
    always_ff @(posedge clk_fast or negedge rst_n) begin
        if (!rst_n) begin
            phase_q <= sd_bus_pkg::rx_idle;
            nib_cnt <= '0;
        end else begin
            case (phase_q)
                sd_bus_pkg::rx_idle: begin
                    // Arm only from idle, a pulse mid-block is dropped
                    if (rx_start) begin
                        phase_q <= sd_bus_pkg::rx_armed;
                    end
                end

                sd_bus_pkg::rx_armed: begin
                    nib_cnt <= '0;
                    if (start_seen) begin
                        phase_q <= sd_bus_pkg::rx_data;
                    end
                end

                sd_bus_pkg::rx_data: begin
                    nib_cnt <= nib_cnt + 1'b1;
                    if (nib_cnt == data_last) begin
                        nib_cnt <= '0;
                        phase_q <= sd_bus_pkg::rx_crc;
                    end
                end

                // Counter is shared, restarted for the CRC bits
                sd_bus_pkg::rx_crc: begin
                    nib_cnt <= nib_cnt + 1'b1;
                    if (nib_cnt == crc_last) begin
                        nib_cnt <= '0;
                        phase_q <= sd_bus_pkg::rx_end_bit;
                    end
                end

                sd_bus_pkg::rx_end_bit: begin
                    phase_q <= sd_bus_pkg::rx_idle;
                end

                default: begin
                    phase_q <= sd_bus_pkg::rx_idle;
                end
            endcase
        end
    end

    // ========================================
    // Stream outputs
    // ========================================
    assign lane.phase       = phase_q;
    assign lane.nibble      = dat_q;
    assign lane.block_start = start_seen;
    assign lane.word_last   = (phase_q == sd_bus_pkg::rx_data) &&
                              (nib_cnt[word_w-1:0] == word_end);

    // Card holds DAT0 low while busy
    assign dat0_idle = dat_q[0];

endmodule

`default_nettype wire

// ==== rtl/sd_lane_crc16.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sd_dat_config.svh"

module sd_lane_crc16 #(
    parameter int LANE = 0
) (
    input  logic     clk_fast,
    input  logic     rst_n,
    sd_lane_if.sink  lane,
    output logic     lane_err
);

    localparam int top = `SD_CRC_BITS - 1;
    localparam sd_crc_pkg::crc16_t poly = sd_crc_pkg::crc16_t'(`SD_CRC16_POLY);

    sd_crc_pkg::crc16_t crc_q;
    logic               bit_in;
    logic               feedback;

    assign bit_in = lane.nibble[LANE];

    // Serial CRC, MSB first, no augmentation
    assign feedback = crc_q[top] ^ bit_in;

    // ========================================
    // Remainder and compare
    // ========================================
    always_ff @(posedge clk_fast or negedge rst_n) begin
        if (!rst_n) begin
            crc_q    <= '0;
            lane_err <= 1'b0;
        end else if (lane.block_start) begin
            crc_q    <= '0;
            lane_err <= 1'b0;
        end else begin
            case (lane.phase)
                sd_bus_pkg::rx_data: begin
                    crc_q <= {crc_q[top-1:0], 1'b0} ^ (feedback ? poly : '0);
                end

                // Remainder now equals the expected CRC, walk it out MSB first
                sd_bus_pkg::rx_crc: begin
                    if (bit_in != crc_q[top]) begin
                        lane_err <= 1'b1;
                    end
                    crc_q <= {crc_q[top-1:0], 1'b0};
                end

                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/sd_block_collector.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sd_dat_config.svh"

module sd_block_collector (
    input  logic                   clk_fast,
    input  logic                   rst_n,
    sd_lane_if.sink                lane,
    input  sd_crc_pkg::lane_err_t  lane_err,
    output logic                   word_valid,
    output sd_bus_pkg::data_word_t word_data,
    output logic                   block_done,
    output logic                   crc_err,
    output logic                   end_err
);

    // Nibbles held before the last one of a word arrives
    localparam int shift_w = (`SD_WORD_NIBBLES - 1) * `SD_LANES;

    logic [shift_w-1:0] word_sr;
    logic               end_seen;
    logic               end_bad;

    // ========================================
    // Word packing
    // ========================================
    always_ff @(posedge clk_fast) begin
        if (lane.phase == sd_bus_pkg::rx_data) begin
            word_sr <= {word_sr[shift_w-`SD_LANES-1:0], lane.nibble};
        end
        // Older nibbles shift toward the top
        if (lane.word_last) begin
            word_data <= {word_sr, lane.nibble};
        end
    end

    always_ff @(posedge clk_fast or negedge rst_n) begin
        if (!rst_n) begin
            word_valid <= 1'b0;
        end else begin
            word_valid <= lane.word_last;
        end
    end

    // ========================================
    // End of block
    // ========================================
    // First stage captures the end nibble, second reports
    always_ff @(posedge clk_fast or negedge rst_n) begin
        if (!rst_n) begin
            end_seen   <= 1'b0;
            end_bad    <= 1'b0;
            block_done <= 1'b0;
            crc_err    <= 1'b0;
            end_err    <= 1'b0;
        end else begin
            end_seen   <= (lane.phase == sd_bus_pkg::rx_end_bit);
            end_bad    <= (lane.phase == sd_bus_pkg::rx_end_bit) && (lane.nibble != '1);
            block_done <= end_seen;

            if (lane.block_start) begin
                crc_err <= 1'b0;
                end_err <= 1'b0;
            end else if (end_seen) begin
                // Lane flags have settled by now
                crc_err <= |lane_err;
                end_err <= end_bad;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/sd_dat_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sd_dat_config.svh"

module sd_dat_rx (
    input  logic                   clk_fast,
    input  logic                   rst_n,
    input  logic                   rx_start,
    input  sd_bus_pkg::nibble_t    dat_in,
    output logic                   word_valid,
    output sd_bus_pkg::data_word_t word_data,
    output logic                   block_done,
    output logic                   crc_err,
    output logic                   end_err,
    output logic                   dat0_idle
);

    sd_lane_if             lane_bus ();
    sd_crc_pkg::lane_err_t lane_err;

    // ========================================
    // Framing
    // ========================================
    sd_dat_framer framer_i (
        .clk_fast  (clk_fast),
        .rst_n     (rst_n),
        .rx_start  (rx_start),
        .dat_in    (dat_in),
        .dat0_idle (dat0_idle),
        .lane      (lane_bus.source)
    );

    // One CRC16 checker per DAT line
    for (genvar i = 0; i < `SD_LANES; i++) begin : g_lane
        sd_lane_crc16 #(
            .LANE (i)
        ) crc_i (
            .clk_fast (clk_fast),
            .rst_n    (rst_n),
            .lane     (lane_bus.sink),
            .lane_err (lane_err[i])
        );
    end

    // ========================================
    // Words and block status
    // ========================================
    sd_block_collector collector_i (
        .clk_fast   (clk_fast),
        .rst_n      (rst_n),
        .lane       (lane_bus.sink),
        .lane_err   (lane_err),
        .word_valid (word_valid),
        .word_data  (word_data),
        .block_done (block_done),
        .crc_err    (crc_err),
        .end_err    (end_err)
    );

endmodule

`default_nettype wire

// ==== verification/sd_tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

// Clock and reset source for the DAT receive testbench
module sd_tb_clock (
    output logic clk_fast,
    output logic rst_n
);

    // 10 ns period
    initial begin
        clk_fast = 1'b0;
        forever #5 clk_fast = ~clk_fast;
    end

    // Reset held for 5 cycles, released away from the rising edge
    initial begin
        rst_n = 1'b0;
        repeat (5) @(posedge clk_fast);
        @(negedge clk_fast);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== verification/sd_dat_rx_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sd_dat_config.svh"

module sd_dat_rx_tb;

    // Five blocks of about 170 cycles, a 30-cycle hold, plus margin
    localparam int timeout_cycles = 2000;
    localparam int done_limit     = 200;
    localparam int num_words      = `SD_BLOCK_NIBBLES / `SD_WORD_NIBBLES;
    localparam logic [15:0] crc_poly = 16'h1021;

    // Cycles from a nibble on dat_in to its response
    localparam int word_lag = 2;
    localparam int done_lag = 3;

    logic                   clk_fast;
    logic                   rst_n;
    logic                   rx_start;
    sd_bus_pkg::nibble_t    dat_in;
    logic                   word_valid;
    sd_bus_pkg::data_word_t word_data;
    logic                   block_done;
    logic                   crc_err;
    logic                   end_err;
    logic                   dat0_idle;

    // Card-side block as driven
    sd_bus_pkg::nibble_t blk_data [0:`SD_BLOCK_NIBBLES-1];
    sd_bus_pkg::nibble_t blk_crc [0:`SD_CRC_BITS-1];
    sd_bus_pkg::nibble_t blk_end;

    // Captured responses
    sd_bus_pkg::data_word_t got_words [$];
    int                     got_word_cycles [$];
    int                     done_count;
    int                     done_cycle;
    int                     start_cycle;
    logic                   done_crc;
    logic                   done_end;
    logic                   idle_at_start;
    logic                   err_after_start;

    int          errors;
    int          checks;
    int          tests;
    int          cycle_count;
    int unsigned seed_init;

    sd_tb_clock clock_i (
        .clk_fast (clk_fast),
        .rst_n    (rst_n)
    );

    sd_dat_rx dut_i (
        .clk_fast   (clk_fast),
        .rst_n      (rst_n),
        .rx_start   (rx_start),
        .dat_in     (dat_in),
        .word_valid (word_valid),
        .word_data  (word_data),
        .block_done (block_done),
        .crc_err    (crc_err),
        .end_err    (end_err),
        .dat0_idle  (dat0_idle)
    );

    // ========================================
    // Response capture
    // ========================================
    always @(negedge clk_fast) begin
        if (rst_n) begin
            if (word_valid === 1'b1) begin
                got_words.push_back(word_data);
                got_word_cycles.push_back(cycle_count);
            end
            if (block_done === 1'b1) begin
                done_count++;
                done_cycle = cycle_count;
                done_crc = crc_err;
                done_end = end_err;
            end
        end
    end

    // ========================================
    // Compare and report
    // ========================================
    task automatic compare_word(input string name, input sd_bus_pkg::data_word_t got,
                                input sd_bus_pkg::data_word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic compare_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic compare_lag(input string name, input int got, input int exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch %s lag: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        tests++;
        if (errors == err_before) begin
            $display("%-28s passed", name);
        end else begin
            $display("%-28s FAILED with %0d errors", name, errors - err_before);
        end
    endtask

    // ========================================
    // Block generation and driving
    // ========================================
    // CRC16-CCITT per lane, zero start, MSB first
    task automatic build_block(input bit random_data, input sd_bus_pkg::nibble_t end_nib);
        sd_crc_pkg::crc16_t crc [`SD_LANES];
        logic               fb;
        for (int i = 0; i < `SD_BLOCK_NIBBLES; i++) begin
            if (random_data) begin
                blk_data[i] = sd_bus_pkg::nibble_t'($urandom);
            end else begin
                blk_data[i] = sd_bus_pkg::nibble_t'(i);
            end
        end
        for (int l = 0; l < `SD_LANES; l++) begin
            crc[l] = '0;
            for (int i = 0; i < `SD_BLOCK_NIBBLES; i++) begin
                fb = crc[l][15] ^ blk_data[i][l];
                crc[l] = {crc[l][14:0], 1'b0} ^ (fb ? crc_poly : 16'h0000);
            end
            for (int k = 0; k < `SD_CRC_BITS; k++) begin
                blk_crc[k][l] = crc[l][15-k];
            end
        end
        blk_end = end_nib;
    endtask

    task automatic clear_capture();
        got_words.delete();
        got_word_cycles.delete();
        done_count = 0;
        done_cycle = 0;
        done_crc   = 1'bx;
        done_end   = 1'bx;
    endtask

    task automatic arm_receiver();
        @(negedge clk_fast);
        rx_start = 1'b1;
        dat_in   = 4'hf;
        @(negedge clk_fast);
        rx_start = 1'b0;
    endtask

    // Start nibble, data, CRC, end nibble, then wait for block_done
    task automatic drive_frame();
        int waited;
        @(negedge clk_fast);
        dat_in = 4'b0000;
        start_cycle = cycle_count;
        waited = 0;
        for (int i = 0; i < `SD_BLOCK_NIBBLES; i++) begin
            @(negedge clk_fast);
            if (i == 0) begin
                idle_at_start = dat0_idle;
            end
            if (i == 1) begin
                err_after_start = crc_err | end_err;
            end
            dat_in = blk_data[i];
            waited++;
        end
        for (int k = 0; k < `SD_CRC_BITS; k++) begin
            @(negedge clk_fast);
            dat_in = blk_crc[k];
            waited++;
        end
        @(negedge clk_fast);
        dat_in = blk_end;
        @(negedge clk_fast);
        dat_in = 4'hf;
        waited += 2;
        while (done_count == 0 && waited < done_limit) begin
            @(posedge clk_fast);
            waited++;
        end
        if (done_count == 0) begin
            errors++;
            $display("block_done did not appear within %0d cycles of the start bit", done_limit);
        end
        // Room for a second, unwanted pulse
        repeat (2) @(posedge clk_fast);
    endtask

    task automatic check_words();
        sd_bus_pkg::data_word_t exp;
        int                     last_nib_cycle;
        if (got_words.size() != num_words) begin
            errors++;
            $display("expected %0d words but received %0d", num_words, got_words.size());
        end else begin
            for (int w = 0; w < num_words; w++) begin
                exp = '0;
                for (int n = 0; n < `SD_WORD_NIBBLES; n++) begin
                    exp = (exp << `SD_LANES) |
                          sd_bus_pkg::data_word_t'(blk_data[w*`SD_WORD_NIBBLES+n]);
                end
                compare_word($sformatf("word_data[%0d]", w), got_words[w], exp);
                // Fourth nibble of the word, counted from the start nibble
                last_nib_cycle = start_cycle + (w + 1) * `SD_WORD_NIBBLES;
                compare_lag($sformatf("word_valid[%0d]", w),
                            got_word_cycles[w] - last_nib_cycle, word_lag);
            end
        end
    endtask

    task automatic check_status(input logic exp_crc, input logic exp_end);
        int end_nib_cycle;
        end_nib_cycle = start_cycle + `SD_BLOCK_NIBBLES + `SD_CRC_BITS + 1;
        if (done_count != 1) begin
            errors++;
            $display("expected one block_done pulse but saw %0d", done_count);
        end else begin
            compare_lag("block_done", done_cycle - end_nib_cycle, done_lag);
            compare_flag("crc_err", done_crc, exp_crc);
            compare_flag("end_err", done_end, exp_end);
        end
    endtask

    // ========================================
    // Directed tests
    // ========================================
    task automatic check_reset_values();
        int err0;
        err0 = errors;
        compare_flag("word_valid", word_valid, 1'b0);
        compare_flag("block_done", block_done, 1'b0);
        compare_flag("crc_err", crc_err, 1'b0);
        compare_flag("end_err", end_err, 1'b0);
        compare_flag("dat0_idle", dat0_idle, 1'b0);
        report_test("reset values", err0);
    endtask

    task automatic run_clean_increment();
        int err0;
        err0 = errors;
        build_block(1'b0, 4'hf);
        clear_capture();
        arm_receiver();
        drive_frame();
        check_words();
        check_status(1'b0, 1'b0);
        report_test("clean incrementing block", err0);
    endtask

    task automatic flip_lane2_bit();
        int err0;
        int idx;
        err0 = errors;
        build_block(1'b1, 4'hf);
        // Corrupt after the CRC is fixed
        idx = $urandom_range(`SD_BLOCK_NIBBLES - 1, 0);
        blk_data[idx][2] = ~blk_data[idx][2];
        clear_capture();
        arm_receiver();
        drive_frame();
        check_words();
        check_status(1'b1, 1'b0);
        report_test("lane 2 data bit flipped", err0);
    endtask

    task automatic recover_after_error();
        int err0;
        err0 = errors;
        build_block(1'b1, 4'hf);
        clear_capture();
        @(negedge clk_fast);
        compare_flag("crc_err before block", crc_err, 1'b1);
        arm_receiver();
        drive_frame();
        compare_flag("crc_err or end_err after start", err_after_start, 1'b0);
        check_words();
        check_status(1'b0, 1'b0);
        report_test("clean block after error", err0);
    endtask

    task automatic corrupt_end_nibble();
        int err0;
        err0 = errors;
        build_block(1'b1, 4'b0111);
        clear_capture();
        arm_receiver();
        drive_frame();
        check_words();
        check_status(1'b0, 1'b1);
        report_test("bad end nibble", err0);
    endtask

    task automatic hold_before_start();
        int err0;
        err0 = errors;
        build_block(1'b1, 4'hf);
        clear_capture();
        arm_receiver();
        repeat (30) begin
            @(negedge clk_fast);
            // Upper lanes low, only DAT0 may start a block
            dat_in = 4'b0001;
            compare_flag("dat0_idle while armed", dat0_idle, 1'b1);
        end
        @(posedge clk_fast);
        compare_flag("word_valid while armed", got_words.size() != 0, 1'b0);
        compare_flag("block_done while armed", done_count != 0, 1'b0);
        drive_frame();
        compare_flag("dat0_idle after start bit", idle_at_start, 1'b0);
        check_words();
        check_status(1'b0, 1'b0);
        report_test("armed hold before start", err0);
    endtask

    // ========================================
    // Run control
    // ========================================
    initial begin
        cycle_count = 0;
        while (cycle_count < timeout_cycles) begin
            @(posedge clk_fast);
            cycle_count++;
        end
        $display("run stopped after %0d cycles without finishing", timeout_cycles);
        $display("Something failed");
        $finish;
    end

    initial begin
        seed_init = $urandom(32'h1f7e);
        rx_start  = 1'b0;
        dat_in    = 4'hf;
        errors    = 0;
        checks    = 0;
        tests     = 0;
        clear_capture();
        wait (rst_n === 1'b1);
        check_reset_values();
        run_clean_increment();
        flip_lane2_bit();
        recover_after_error();
        corrupt_end_nibble();
        hold_before_start();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sd_dat_rx.f ====
+incdir+include
rtl/sd_bus_pkg.sv
rtl/sd_crc_pkg.sv
rtl/sd_lane_if.sv
rtl/sd_dat_framer.sv
rtl/sd_lane_crc16.sv
rtl/sd_block_collector.sv
rtl/sd_dat_rx.sv
verification/sd_tb_clock.sv
verification/sd_dat_rx_tb.sv
